// ==== logic/smc_pkg.sv ====
package smc_pkg;

  // --------------------------------------------------------------------
  // APB register map (5-bit word-aligned offsets)
  // --------------------------------------------------------------------
  localparam logic [4:0] REG_CONFIG = 5'h00;  // Wait-state configuration
  localparam logic [4:0] REG_ADDR   = 5'h04;  // External word address
  localparam logic [4:0] REG_DATA   = 5'h08;  // Window onto external memory
  localparam logic [4:0] REG_STATUS = 5'h0C;  // Access count, read only

  // --------------------------------------------------------------------
  // Configuration register fields
  // --------------------------------------------------------------------
  localparam int WAIT_W      = 4;   // Read / write wait-state count
  localparam int TURN_W      = 2;   // Turnaround idle count
  localparam int RD_WAIT_LSB = 0;   // Bits 3:0
  localparam int WR_WAIT_LSB = 4;   // Bits 7:4
  localparam int TURN_LSB    = 8;   // Bits 9:8
  localparam int CONFIG_W    = 10;  // Stored bits, rest read as zero

  // Read 2, write 1, turnaround 1
  localparam logic [CONFIG_W-1:0] CONFIG_RESET = 10'h112;

  // --------------------------------------------------------------------
  // Access sequencer states
  // --------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'd0,  // Waiting for a request
    ST_STROBE = 2'd1,  // Chip select and strobe active
    ST_DONE   = 2'd2,  // Access complete, one cycle
    ST_TURN   = 2'd3   // Bus turnaround idle
  } access_state_t;

endpackage

// ==== logic/smc_apb_if.sv ====
module smc_apb_if #(
  parameter int ADDR_W = 16  // External word-address width
) (
  input  logic                       pclk,
  input  logic                       rst,
  // APB slave
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [4:0]                 paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  // Sequencer handshake
  input  logic                       done,
  input  logic                       busy,
  input  logic [31:0]                rdata_held,
  output logic                       req,
  output logic                       req_write,
  output logic [ADDR_W-1:0]          req_addr,
  output logic [31:0]                req_wdata,
  // Unpacked timing fields
  output logic [smc_pkg::WAIT_W-1:0] rd_wait,
  output logic [smc_pkg::WAIT_W-1:0] wr_wait,
  output logic [smc_pkg::TURN_W-1:0] turn_wait
);

  import smc_pkg::*;

  localparam int CNT_W = 16;  // Status counter width

  logic                apb_access;   // Access phase of a transfer
  logic                sel_config;
  logic                sel_addr;
  logic                sel_data;
  logic                sel_status;
  logic                unmapped;     // No register at this offset
  logic                reg_wr;       // Register write this cycle
  logic                req_pending;  // Window request sent, not yet done
  logic [CONFIG_W-1:0] config_reg;
  logic [ADDR_W-1:0]   addr_reg;
  logic [CNT_W-1:0]    access_cnt;   // Data-window accesses since reset

  // --------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------
  assign apb_access = psel & penable;
  assign sel_config = (paddr == REG_CONFIG);
  assign sel_addr   = (paddr == REG_ADDR);
  assign sel_data   = (paddr == REG_DATA);
  assign sel_status = (paddr == REG_STATUS);
  assign unmapped   = ~(sel_config | sel_addr | sel_data | sel_status);
  assign reg_wr     = apb_access & pwrite;

  // Register accesses finish at once, window waits for the sequencer
  assign pready  = apb_access & (sel_data ? done : 1'b1);
  assign pslverr = apb_access & unmapped;

  // Read mux
  always_comb
  begin
    prdata = '0;
    if (apb_access & ~pwrite)
    begin
      if (sel_config)
        prdata = 32'(config_reg);
      else if (sel_addr)
        prdata = 32'(addr_reg);
      else if (sel_data)
        prdata = rdata_held;  // Captured in the last strobe cycle
      else if (sel_status)
        prdata = 32'(access_cnt);
    end
  end

  // --------------------------------------------------------------------
  // Data-window request
  // --------------------------------------------------------------------
  // One pulse per transfer, held off while the sequencer turns around
  assign req       = apb_access & sel_data & ~req_pending & ~busy;
  assign req_write = pwrite;
  assign req_addr  = addr_reg;
  assign req_wdata = pwdata;

  always_ff @(posedge pclk)
  begin
    if (rst)
      req_pending <= 1'b0;
    else if (done)
      req_pending <= 1'b0;  // Transfer completes this cycle
    else if (req)
      req_pending <= 1'b1;
  end

  // --------------------------------------------------------------------
  // Configuration, address and status registers
  // --------------------------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (rst)
    begin
      config_reg <= CONFIG_RESET;
      addr_reg   <= '0;
      access_cnt <= '0;
    end
    else
    begin
      if (reg_wr & sel_config)
        config_reg <= pwdata[CONFIG_W-1:0];
      if (reg_wr & sel_addr)
        addr_reg <= pwdata[ADDR_W-1:0];
      else if (done)
        addr_reg <= addr_reg + 1'b1;  // Auto-increment per window access
      if (done)
        access_cnt <= access_cnt + 1'b1;  // Wraps at 16 bits
    end
  end

  // Field unpack
  assign rd_wait   = config_reg[RD_WAIT_LSB +: WAIT_W];
  assign wr_wait   = config_reg[WR_WAIT_LSB +: WAIT_W];
  assign turn_wait = config_reg[TURN_LSB +: TURN_W];

endmodule

// ==== logic/smc_access_ctrl.sv ====
module smc_access_ctrl #(
  parameter int ADDR_W = 16  // External word-address width
) (
  input  logic                       pclk,
  input  logic                       rst,
  // Request from the APB side
  input  logic                       req,
  input  logic                       req_write,
  input  logic [ADDR_W-1:0]          req_addr,
  input  logic [31:0]                req_wdata,
  input  logic [smc_pkg::WAIT_W-1:0] rd_wait,
  input  logic [smc_pkg::WAIT_W-1:0] wr_wait,
  input  logic [smc_pkg::TURN_W-1:0] turn_wait,
  output logic                       done,
  output logic                       busy,
  // Unregistered memory controls, active high
  output logic                       mem_cs,
  output logic                       mem_oe,
  output logic                       mem_we,
  output logic [ADDR_W-1:0]          mem_addr,
  output logic [31:0]                mem_wdata,
  output logic                       capture
);

  import smc_pkg::*;

  access_state_t     state;
  logic [WAIT_W-1:0] wait_cnt;  // Down-counter for strobe and turnaround
  logic              cnt_zero;
  logic              write_q;   // Latched direction
  logic [ADDR_W-1:0] addr_q;
  logic [31:0]       wdata_q;

  assign cnt_zero = (wait_cnt == '0);

  // --------------------------------------------------------------------
  // Sequencer
  // --------------------------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (req)
          begin
            state    <= ST_STROBE;
            wait_cnt <= req_write ? wr_wait : rd_wait;  // Width is wait+1
          end
        end
        ST_STROBE:
        begin
          if (cnt_zero)
            state <= ST_DONE;
          else
            wait_cnt <= wait_cnt - 1'b1;
        end
        ST_DONE:
        begin
          // Skip turnaround when the field is zero
          if (turn_wait == '0)
            state <= ST_IDLE;
          else
          begin
            state    <= ST_TURN;
            wait_cnt <= WAIT_W'(turn_wait) - 1'b1;
          end
        end
        ST_TURN:
        begin
          if (cnt_zero)
            state <= ST_IDLE;
          else
            wait_cnt <= wait_cnt - 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request payload, taken once on acceptance
  always_ff @(posedge pclk)
  begin
    if ((state == ST_IDLE) && req)
    begin
      write_q <= req_write;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  // --------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------
  assign mem_cs    = (state == ST_STROBE);
  assign mem_oe    = mem_cs & ~write_q;
  assign mem_we    = mem_cs & write_q;
  assign mem_addr  = addr_q;
  assign mem_wdata = wdata_q;
  assign capture   = mem_oe & cnt_zero;  // Last read strobe cycle
  assign done      = (state == ST_DONE);
  assign busy      = (state != ST_IDLE);

endmodule

// ==== logic/smc_ext_if.sv ====
module smc_ext_if #(
  parameter int ADDR_W = 16  // External word-address width
) (
  input  logic              pclk,
  input  logic              rst,
  // From the sequencer
  input  logic              mem_cs,
  input  logic              mem_oe,
  input  logic              mem_we,
  input  logic [ADDR_W-1:0] mem_addr,
  input  logic [31:0]       mem_wdata,
  input  logic              capture,
  // SRAM pins
  input  logic [31:0]       mem_dq_in,
  output logic              mem_cs_n,
  output logic              mem_oe_n,
  output logic              mem_we_n,
  output logic [ADDR_W-1:0] mem_a,
  output logic [31:0]       mem_dq_out,
  // Back to the APB side
  output logic [31:0]       rdata_held
);

  logic        capture_q;  // Aligned with the last pin strobe cycle
  logic [31:0] rdata_q;

  // --------------------------------------------------------------------
  // Pin registers, one cycle behind the sequencer
  // --------------------------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (rst)
    begin
      mem_cs_n  <= 1'b1;  // All strobes inactive
      mem_oe_n  <= 1'b1;
      mem_we_n  <= 1'b1;
      capture_q <= 1'b0;
    end
    else
    begin
      mem_cs_n  <= ~mem_cs;
      mem_oe_n  <= ~mem_oe;
      mem_we_n  <= ~mem_we;
      capture_q <= capture;
    end
  end

  always_ff @(posedge pclk)
  begin
    mem_a      <= mem_addr;
    mem_dq_out <= mem_wdata;
  end

  // Read data capture
  always_ff @(posedge pclk)
  begin
    if (capture_q)
      rdata_q <= mem_dq_in;
  end

  // Bus value passes straight through in the capture cycle
  assign rdata_held = capture_q ? mem_dq_in : rdata_q;

endmodule

// ==== logic/smc_lite_top.sv ====
module smc_lite_top #(
  parameter int ADDR_W = 16  // External word-address width
) (
  input  logic              pclk,
  input  logic              rst,
  // APB slave port
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [4:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  // Asynchronous SRAM
  output logic              mem_cs_n,
  output logic              mem_oe_n,
  output logic              mem_we_n,
  output logic [ADDR_W-1:0] mem_a,
  output logic [31:0]       mem_dq_out,
  input  logic [31:0]       mem_dq_in
);

  import smc_pkg::*;

  // APB side to sequencer
  logic              req;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  logic [31:0]       req_wdata;
  logic [WAIT_W-1:0] rd_wait;
  logic [WAIT_W-1:0] wr_wait;
  logic [TURN_W-1:0] turn_wait;
  logic              done;
  logic              busy;
  // Sequencer to pin stage
  logic              mem_cs;
  logic              mem_oe;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  logic [31:0]       mem_wdata;
  logic              capture;
  logic [31:0]       rdata_held;  // Last captured read word

  // --------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------
  smc_apb_if #(.ADDR_W(ADDR_W)) u_apb_if (
    .pclk       (pclk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .done       (done),
    .busy       (busy),
    .rdata_held (rdata_held),
    .req        (req),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .rd_wait    (rd_wait),
    .wr_wait    (wr_wait),
    .turn_wait  (turn_wait)
  );

  smc_access_ctrl #(.ADDR_W(ADDR_W)) u_access_ctrl (
    .pclk      (pclk),
    .rst       (rst),
    .req       (req),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rd_wait   (rd_wait),
    .wr_wait   (wr_wait),
    .turn_wait (turn_wait),
    .done      (done),
    .busy      (busy),
    .mem_cs    (mem_cs),
    .mem_oe    (mem_oe),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .capture   (capture)
  );

  smc_ext_if #(.ADDR_W(ADDR_W)) u_ext_if (
    .pclk       (pclk),
    .rst        (rst),
    .mem_cs     (mem_cs),
    .mem_oe     (mem_oe),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .capture    (capture),
    .mem_dq_in  (mem_dq_in),
    .mem_cs_n   (mem_cs_n),
    .mem_oe_n   (mem_oe_n),
    .mem_we_n   (mem_we_n),
    .mem_a      (mem_a),
    .mem_dq_out (mem_dq_out),
    .rdata_held (rdata_held)
  );

endmodule

// ==== verification/smc_sram_model.sv ====
module smc_sram_model #(
  parameter int ADDR_W = 16  // Word-address width
) (
  input  logic              mem_cs_n,
  input  logic              mem_oe_n,
  input  logic              mem_we_n,
  input  logic [ADDR_W-1:0] mem_a,
  input  logic [31:0]       mem_dq_out,
  output logic [31:0]       mem_dq_in,
  // Backdoor read for the checker
  input  logic [ADDR_W-1:0] peek_addr,
  output logic [31:0]       peek_data
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [31:0] mem [0:DEPTH-1];
  logic        write_open = 1'b0;  // we_n low, write not yet committed

  // Fill pattern uses every address bit
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = 32'h5A5A_0000 ^ 32'(i) ^ (32'(i) << 16);
  end

  // Write commits on the rising edge of we_n, like a real async part
  always @(mem_we_n)
  begin
    if (!mem_we_n)
      write_open = 1'b1;
    else if (write_open)
    begin
      mem[mem_a] = mem_dq_out;  // Address and data held by the DUT
      write_open = 1'b0;
    end
  end

  // Async read path, bus reads zero when not driven
  assign mem_dq_in = (!mem_cs_n && !mem_oe_n) ? mem[mem_a] : 32'h0;
  assign peek_data = mem[peek_addr];

endmodule

// ==== verification/smc_checker.sv ====
module smc_checker (
  input  logic        pclk,
  input  logic        rst,
  // APB port of the DUT
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic [31:0] prdata,
  input  logic        pready,
  input  logic        pslverr,
  // Memory strobes and SRAM backdoor
  input  logic        mem_cs_n,
  input  logic        mem_oe_n,
  input  logic        mem_we_n,
  input  logic [31:0] peek_data,
  // Expectations from the driver
  input  logic [3:0]  test_id,
  input  logic [31:0] exp_data,
  input  logic        exp_err,
  input  logic        check_read,
  input  logic        mem_check,
  output int          error_count,
  output int          check_count
);

  int         rd_width;     // Expected oe_n low cycles
  int         wr_width;     // Expected we_n low cycles
  int         oe_low;
  int         we_low;
  int         wait_cycles;  // Access-phase cycles with pready low
  logic [3:0] done_id;      // Test of the last completed transfer

  function automatic string test_label(input logic [3:0] id);
    case (id)
      4'd1:    return "reset_config";
      4'd2:    return "config_rw";
      4'd3:    return "window_write";
      4'd4:    return "window_read";
      4'd5:    return "sram_contents";
      4'd6:    return "auto_increment";
      4'd7:    return "strobe_width";
      4'd8:    return "unmapped";
      4'd9:    return "status_count";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string what, input logic [3:0] id,
                         input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("FAIL %s %s: expected %h actual %h", test_label(id), what, expected, actual);
    end
  endtask

  always @(posedge pclk)
  begin
    if (rst)
    begin
      error_count = 0;
      check_count = 0;
      rd_width    = 3;  // Reset config has read 2
      wr_width    = 2;  // Write 1
      oe_low      = 0;
      we_low      = 0;
      wait_cycles = 0;
      done_id     = '0;
    end
    else
    begin
      // ----------------------------------------------------------------------
      // APB completions
      // ----------------------------------------------------------------------
      if (psel && penable && pready)
      begin
        if (check_read && !pwrite)
          compare("prdata", test_id, exp_data, prdata);
        compare("pslverr", test_id, {31'b0, exp_err}, {31'b0, pslverr});
        if (paddr != 5'h08)
          compare("wait cycles", test_id, 32'd0, wait_cycles);  // Registers never wait
        if (pwrite && paddr == 5'h00)
        begin
          rd_width = int'(pwdata[3:0]) + 1;  // Strobe is wait+1 cycles
          wr_width = int'(pwdata[7:4]) + 1;
        end
        done_id     = test_id;
        wait_cycles = 0;
      end
      else if (psel && penable)
        wait_cycles++;

      // ----------------------------------------------------------------------
      // Strobe widths at the pins
      // ----------------------------------------------------------------------
      if (!mem_oe_n)
        oe_low++;
      else if (oe_low != 0)
      begin
        compare("oe_n width", done_id, rd_width, oe_low);
        oe_low = 0;
      end
      if (!mem_we_n)
        we_low++;
      else if (we_low != 0)
      begin
        compare("we_n width", done_id, wr_width, we_low);
        we_low = 0;
      end

      // Chip select low exactly while a strobe is low
      if (!mem_cs_n || !mem_oe_n || !mem_we_n)
        compare("cs_n", test_id, {31'b0, mem_oe_n & mem_we_n}, {31'b0, mem_cs_n});

      if (mem_check)
        compare("sram word", test_id, exp_data, peek_data);  // Backdoor view
    end
  end

endmodule

// ==== verification/smc_tb.sv ====
module smc_tb;

  localparam int ADDR_W  = 16;
  localparam int MAX_VEC = 32;   // Vector lines of four words each
  localparam int TIMEOUT = 200;  // Cycles allowed for pready

  logic              pclk;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [4:0]        paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              mem_cs_n;
  logic              mem_oe_n;
  logic              mem_we_n;
  logic [ADDR_W-1:0] mem_a;
  logic [31:0]       mem_dq_out;
  logic [31:0]       mem_dq_in;
  logic [ADDR_W-1:0] peek_addr;
  logic [31:0]       peek_data;
  // Expectations handed to the checker
  logic [3:0]        test_id;
  logic [31:0]       exp_data;
  logic              exp_err;
  logic              check_read;
  logic              mem_check;
  int                error_count;
  int                check_count;
  int                tb_errors;  // Timeouts and bad vectors
  logic [31:0]       vec_mem [0:4*MAX_VEC-1];  // Op, test, offset and data words

  always #10 pclk = ~pclk;

  smc_lite_top #(.ADDR_W(ADDR_W)) dut (
    .pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .mem_cs_n(mem_cs_n), .mem_oe_n(mem_oe_n), .mem_we_n(mem_we_n), .mem_a(mem_a),
    .mem_dq_out(mem_dq_out), .mem_dq_in(mem_dq_in)
  );

  smc_sram_model #(.ADDR_W(ADDR_W)) u_sram (
    .mem_cs_n(mem_cs_n), .mem_oe_n(mem_oe_n), .mem_we_n(mem_we_n), .mem_a(mem_a),
    .mem_dq_out(mem_dq_out), .mem_dq_in(mem_dq_in),
    .peek_addr(peek_addr), .peek_data(peek_data)
  );

  smc_checker u_checker (
    .pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .mem_cs_n(mem_cs_n), .mem_oe_n(mem_oe_n), .mem_we_n(mem_we_n), .peek_data(peek_data),
    .test_id(test_id), .exp_data(exp_data), .exp_err(exp_err),
    .check_read(check_read), .mem_check(mem_check),
    .error_count(error_count), .check_count(check_count)
  );

  // ------------------------------------------------------------------------
  // APB driver with setup then access phase until pready
  // ------------------------------------------------------------------------
  task automatic apb_transfer(input logic write, input logic [4:0] addr,
                              input logic [31:0] data, output logic timed_out);
    int waited;
    waited    = 0;
    timed_out = 1'b0;
    @(posedge pclk);
    #2;
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk);
    #2;
    penable = 1'b1;
    @(negedge pclk);  // pready settled mid-cycle
    while (!pready && waited < TIMEOUT)
    begin
      @(negedge pclk);
      waited++;
    end
    if (!pready)
      timed_out = 1'b1;
    @(posedge pclk);  // Completion edge
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One-cycle pulse for the backdoor compare in the checker
  task automatic check_memory(input logic [ADDR_W-1:0] addr);
    @(posedge pclk);
    #2;
    peek_addr = addr;
    mem_check = 1'b1;
    @(posedge pclk);
    #2;
    mem_check = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // Vector sequence
  // ------------------------------------------------------------------------
  initial
  begin
    int         idx;
    logic [3:0] op;
    logic       timed_out;
    pclk       = 1'b0;
    rst        = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    peek_addr  = '0;
    test_id    = '0;
    exp_data   = '0;
    exp_err    = 1'b0;
    check_read = 1'b0;
    mem_check  = 1'b0;
    tb_errors  = 0;
    timed_out  = 1'b0;
    for (idx = 0; idx < 4*MAX_VEC; idx++)
      vec_mem[idx] = '0;  // Op 0 ends the list
    $readmemh("verification/smc_vectors.txt", vec_mem);
    repeat (2) @(posedge pclk);
    #2;
    rst = 1'b0;
    idx = 0;
    while (idx < MAX_VEC && vec_mem[4*idx] != '0 && !timed_out)
    begin
      op         = vec_mem[4*idx][3:0];
      test_id    = vec_mem[4*idx+1][3:0];
      exp_data   = vec_mem[4*idx+3];
      exp_err    = (op == 4'd3);
      check_read = (op == 4'd2) || (op == 4'd3);
      case (op)
        4'd1:       apb_transfer(1'b1, vec_mem[4*idx+2][4:0], exp_data, timed_out);
        4'd2, 4'd3: apb_transfer(1'b0, vec_mem[4*idx+2][4:0], 32'h0, timed_out);
        4'd4:       check_memory(vec_mem[4*idx+2][ADDR_W-1:0]);
        default:
        begin
          $display("Vector %0d has an unknown operation code %0d", idx, op);
          tb_errors++;
        end
      endcase
      if (timed_out)
      begin
        $display("Timeout: pready never came within %0d cycles at vector %0d", TIMEOUT, idx);
        tb_errors++;
      end
      idx++;
    end
    if (idx == 0)
    begin
      $display("No vectors were read from the vector file");
      tb_errors++;
    end
    repeat (4) @(posedge pclk);  // Let the last strobe check land
    $display("%0d checks, %0d errors", check_count, error_count + tb_errors);
    if (error_count == 0 && tb_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/smc_pkg.sv
logic/smc_apb_if.sv
logic/smc_access_ctrl.sv
logic/smc_ext_if.sv
logic/smc_lite_top.sv
verification/smc_sram_model.sv
verification/smc_checker.sv
verification/smc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the SMC testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f filelist.f --top-module smc_tb -o smc_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/smc_sim > "$log" 2>&1 \
  || { cat "$log"; echo "Simulation exited with an error"; exit 1; }

cat "$log"
grep -q "FAIL: see errors above" "$log" \
  && { echo "Simulation failed"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

// ==== verification/smc_vectors.txt ====
// op test offset data. op 1 write, 2 read and compare, 3 read expecting pslverr, 4 SRAM word
// test 1 reset_config 2 config_rw 3..5 window 6 auto_increment 7 strobe_width 8 unmapped 9 status
2 1 00 00000112
1 2 00 00000235
2 2 00 00000235
1 3 04 00000010
1 3 08 CAFE0001
1 3 08 12345678
1 3 08 A5A50F0F
2 6 04 00000013
1 4 04 00000010
2 4 08 CAFE0001
2 4 08 12345678
2 4 08 A5A50F0F
4 5 10 CAFE0001
4 5 12 A5A50F0F
1 7 00 00000000
2 7 08 5A490013
1 7 00 0000037F
1 7 08 0BADF00D
2 7 08 5A4F0015
3 8 10 00000000
2 9 0C 00000009
4 5 14 0BADF00D
